// File: compile.f
src/isaPkg.sv
src/frontPkg.sv
src/jumpDecoder.sv
src/instrClassifier.sv
src/branchResolver.sv
src/branchDecodeTop.sv
bench/branchResolver_sva.sv
bench/branchChecker.sv
bench/tbBranchDecode.sv

// File: Bender.yml
package:
  name: branch_decode

sources:
  - src/isaPkg.sv
  - src/frontPkg.sv
  - src/jumpDecoder.sv
  - src/instrClassifier.sv
  - src/branchResolver.sv
  - src/branchDecodeTop.sv
  - target: test
    files:
      - bench/branchResolver_sva.sv
      - bench/branchChecker.sv
      - bench/tbBranchDecode.sv

// File: bench/tbBranchDecode.sv
// ----------------------------------------
// Testbench for the branch-decode slice.
// Inputs change 1 ns after the rising edge.
// The checker does all result comparison.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tbBranchDecode;

  import isaPkg::*;
  import frontPkg::*;

  localparam int clkPeriod  = 8;
  localparam int numItems   = 16 * 3 * 2 + 20 + 16 + 20 + 20 + 200;
  localparam int watchdogNs = (numItems + 20) * clkPeriod;

  logic          clk = 1'b0;
  logic          rstN;
  logic          valid;
  logic [47:0]   instr;
  lenCode_e      magic;
  logic [47:0]   ip;
  logic [3:0]    flags;
  logic [47:0]   regTarget;
  logic          outValid;
  branchResult_t result;
  int            errorCount;
  int            checkCount;
  int            issued = 0;
  int            svaFails;

  always #(clkPeriod / 2) clk = ~clk;

  branchDecodeTop UUT (.*);

  branchChecker uChecker (.*);

  function automatic logic [47:0] randWord();
    return {16'($urandom()), $urandom()};
  endfunction

  function automatic lenCode_e randLen();
    case ($urandom_range(2, 0))
      0:       return lenShort;
      1:       return lenMid;
      default: return lenLong;
    endcase
  endfunction

  function automatic logic [47:0] groupWord(input logic [2:0] sub);
    logic [47:0] w;
    w = randWord();
    return {w[47:16], sub, w[12:8], 8'hB6};
  endfunction

  // Any opcode outside A0..AF, B5 and B6.
  function automatic logic [47:0] plainWord();
    logic [47:0] w;
    do begin
      w = randWord();
    end while (w[7:4] == 4'hA || w[7:0] == 8'hB5 || w[7:0] == 8'hB6);
    return w;
  endfunction

  task automatic sendInstr(input logic [47:0] w, input lenCode_e len);
    @(posedge clk);
    #1;
    valid     = 1'b1;
    instr     = w;
    magic     = len;
    ip        = randWord();
    flags     = 4'($urandom());
    regTarget = randWord();
    issued    = issued + 1;
  endtask

  task automatic idleCycle();
    @(posedge clk);
    #1;
    valid = 1'b0;
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    int k;
    void'($urandom(32'h5c07_52f7));
    rstN = 1'b0;
    valid = 1'b0;
    instr = '0;
    magic = lenShort;
    ip = '0;
    flags = '0;
    regTarget = '0;
    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;
    for (int c = 0; c < 16; c++) begin  // Conditional range, every length.
      for (int r = 0; r < 6; r++) begin
        sendInstr({40'(randWord() >> 8), 4'hA, 4'(c)},
                  (r < 2) ? lenShort : ((r < 4) ? lenMid : lenLong));
      end
    end
    for (k = 0; k < 10; k++) begin
      sendInstr({40'(randWord() >> 8), 8'hB5}, randLen());
      sendInstr(groupWord(3'd0), randLen());  // Indirect.
    end
    repeat (2) begin  // Nested calls, then matching returns.
      repeat (4) sendInstr(groupWord(3'd1), randLen());
      repeat (4) sendInstr(groupWord(3'd3), randLen());
    end
    repeat (10) sendInstr(groupWord(3'd1), randLen());  // Overflows the stack.
    repeat (10) sendInstr(groupWord(3'd3), randLen());  // Last two underflow.
    for (k = 0; k < 10; k++) begin
      sendInstr((k % 2 == 0) ? groupWord(3'd1) : randWord(), lenIllegal);
      sendInstr(plainWord(), randLen());
    end
    for (k = 0; k < 200; k++) begin  // Random mix with idle gaps.
      if ($urandom_range(3, 0) == 0) begin
        idleCycle();
      end else begin
        case ($urandom_range(5, 0))
          0:       sendInstr({40'(randWord() >> 8), 4'hA, 4'($urandom())},
                             lenCode_e'($urandom()));
          1:       sendInstr({40'(randWord() >> 8), 8'hB5}, lenCode_e'($urandom()));
          2:       sendInstr(groupWord(3'($urandom())), lenCode_e'($urandom()));
          3:       sendInstr(plainWord(), lenCode_e'($urandom()));
          4:       sendInstr(groupWord(3'd1), randLen());
          default: sendInstr(groupWord(3'd3), randLen());
        endcase
      end
    end
    idleCycle();
    repeat (3) @(posedge clk);
    svaFails = UUT.uBranchResolver.uResolverSva.failCount;
    if (checkCount != issued) $display("Only %0d of %0d results were checked", checkCount, issued);
    $display("Checks %0d, errors %0d, assertion failures %0d", checkCount, errorCount, svaFails);
    if (errorCount == 0 && svaFails == 0 && checkCount == issued) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // ----------------------------------------
  // Watchdog
  // ----------------------------------------
  initial begin
    #(watchdogNs);
    $display("Watchdog expired after %0d ns, the run did not finish", watchdogNs);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/branchChecker.sv
// ----------------------------------------
// Watches the top-level ports and compares
// each result against a reference model
// with its own return stack (newest 8 kept).
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module branchChecker (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          valid,
  input  logic [isaPkg::instrWidth-1:0] instr,
  input  isaPkg::lenCode_e              magic,
  input  logic [isaPkg::ipWidth-1:0]    ip,
  input  logic [3:0]                    flags,
  input  logic [isaPkg::ipWidth-1:0]    regTarget,
  input  logic                          outValid,
  input  frontPkg::branchResult_t       result,
  output int                            errorCount,
  output int                            checkCount
);

  import isaPkg::*;
  import frontPkg::*;

  logic [ipWidth-1:0] modelStack [$];  // Back is the newest entry.
  branchResult_t      expected;
  logic               pending = 1'b0;
  int                 errCnt = 0;
  int                 chkCnt = 0;

  assign errorCount = errCnt;
  assign checkCount = chkCnt;

  // Flag test from the condition table, flags are N Z C V.
  function automatic logic condTrue(input logic [3:0] code, input logic [3:0] f);
    logic t;
    case (code[3:1])
      3'd0:    t = f[2];
      3'd1:    t = f[1];
      3'd2:    t = f[3];
      3'd3:    t = f[0];
      3'd4:    t = f[1] | f[2];
      3'd5:    t = f[3] ^ f[0];
      3'd6:    t = (f[3] ^ f[0]) | f[2];
      default: t = 1'b1;
    endcase
    return t ^ code[0];
  endfunction

  // Expected result; also updates the stack model.
  function automatic branchResult_t refResult(input logic [47:0] word, input lenCode_e len,
                                              input logic [47:0] pc, input logic [3:0] f,
                                              input logic [47:0] reg_);
    branchResult_t r;
    logic [47:0]   fall;
    logic [47:0]   off;
    logic [47:0]   target;
    logic [7:0]    op;
    logic [2:0]    sub;
    r   = '0;
    op  = word[7:0];
    sub = word[15:13];
    case (len)
      lenShort: off = {{40{word[15]}}, word[15:8]} << 1;
      lenMid:   off = {{32{word[31]}}, word[31:16]} << 1;
      default:  off = {{16{word[47]}}, word[47:16]} << 1;
    endcase
    fall   = pc + ((len == lenShort) ? 48'd2 : (len == lenMid) ? 48'd4 : 48'd6);
    target = pc + off;
    if (len == lenIllegal) begin
      r.illegal = 1'b1;  // No stack change.
    end else if (op[7:4] == 4'hA) begin
      r.taken = condTrue(op[3:0], f);
    end else if (op == 8'hB5) begin
      r.taken = 1'b1;
    end else if (op == 8'hB6 && sub == 3'd0) begin
      r.taken = 1'b1;
      target  = reg_;
    end else if (op == 8'hB6 && sub == 3'd1) begin
      r.taken = 1'b1;
      if (modelStack.size() == rasDepth) void'(modelStack.pop_front());  // Drop oldest.
      modelStack.push_back(fall);
    end else if (op == 8'hB6 && sub == 3'd3) begin
      if (modelStack.size() == 0) begin
        r.rasUnderflow = 1'b1;
      end else begin
        r.taken = 1'b1;
        target  = modelStack.pop_back();
      end
    end
    r.nextIp = r.illegal ? pc : (r.taken ? target : fall);
    return r;
  endfunction

  // ----------------------------------------
  // Compare at the edge after each valid
  // ----------------------------------------
  always @(posedge clk) begin
    if (!rstN) begin
      modelStack.delete();
      pending = 1'b0;
    end else begin
      if (pending) begin
        chkCnt = chkCnt + 1;
        if (outValid !== 1'b1) begin
          errCnt = errCnt + 1;
          $display("Error at %0t: no outValid one cycle after an instruction", $time);
        end else if (result !== expected) begin
          errCnt = errCnt + 1;
          $display("Fail at %0t: got nextIp %h taken %b illegal %b underflow %b, want %h %b %b %b",
                   $time, result.nextIp, result.taken, result.illegal, result.rasUnderflow,
                   expected.nextIp, expected.taken, expected.illegal, expected.rasUnderflow);
        end
      end else if (outValid !== 1'b0) begin
        errCnt = errCnt + 1;
        $display("Error at %0t: outValid high with no instruction a cycle earlier", $time);
      end
      pending = valid;
      if (valid) expected = refResult(instr, magic, ip, flags, regTarget);
    end
  end

endmodule

`default_nettype wire

// File: bench/branchResolver_sva.sv
// ----------------------------------------
// Concurrent checks bound into the resolver.
// Reset is synchronous, so the follow check
// starts one cycle after rstN goes high.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module branchResolverSva (
  input logic                    clk,
  input logic                    rstN,
  input logic                    valid,
  input logic                    outValid,
  input frontPkg::branchResult_t result
);

  int failCount = 0;

  // One registered stage from valid to outValid.
  assertFollow: assert property (@(posedge clk) $past(rstN) |-> (outValid == $past(valid)))
    else begin
      failCount = failCount + 1;
      $error("outValid did not follow valid by one cycle");
    end

  assertResetLow: assert property (@(posedge clk) !rstN |=> !outValid)
    else begin
      failCount = failCount + 1;
      $error("outValid high after a reset cycle");
    end

  assertTakenLegal: assert property (@(posedge clk) disable iff (!rstN)
                                     result.taken |-> !result.illegal)
    else begin
      failCount = failCount + 1;
      $error("taken set together with illegal");
    end

endmodule

bind branchResolver branchResolverSva uResolverSva (
  .clk      (clk),
  .rstN     (rstN),
  .valid    (valid),
  .outValid (outValid),
  .result   (result)
);

`default_nettype wire

// File: src/branchDecodeTop.sv
// ----------------------------------------
// Branch-decode slice. Result appears one
// cycle after valid, with no back-pressure.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module branchDecodeTop (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          valid,
  input  logic [isaPkg::instrWidth-1:0] instr,
  input  isaPkg::lenCode_e              magic,
  input  logic [isaPkg::ipWidth-1:0]    ip,
  input  logic [3:0]                    flags,     // N, Z, C, V.
  input  logic [isaPkg::ipWidth-1:0]    regTarget,
  output logic                          outValid,
  output frontPkg::branchResult_t       result
);

  import frontPkg::*;

  jumpInfo_t  jump;
  classInfo_t info;

  jumpDecoder uJumpDecoder (
    .instr (instr),
    .jump  (jump)
  );

  instrClassifier uInstrClassifier (
    .instr (instr),
    .magic (magic),
    .info  (info)
  );

  branchResolver uBranchResolver (
    .clk       (clk),
    .rstN      (rstN),
    .valid     (valid),
    .ip        (ip),
    .flags     (flags),
    .regTarget (regTarget),
    .jump      (jump),
    .info      (info),
    .outValid  (outValid),
    .result    (result)
  );

endmodule

`default_nettype wire

// File: src/branchResolver.sv
// ----------------------------------------
// Evaluates the condition, picks the next
// fetch address and keeps a circular return
// stack. One registered stage; a full stack
// overwrites its oldest entry on a call.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module branchResolver (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       valid,
  input  logic [isaPkg::ipWidth-1:0] ip,
  input  logic [3:0]                 flags,
  input  logic [isaPkg::ipWidth-1:0] regTarget,
  input  frontPkg::jumpInfo_t        jump,
  input  frontPkg::classInfo_t       info,
  output logic                       outValid,
  output frontPkg::branchResult_t    result
);

  import isaPkg::*;
  import frontPkg::*;

  logic               n, z, c, v;
  logic [3:0]         condBits;
  logic               condTest;
  logic               condHolds;
  logic [ipWidth-1:0] fallThru;
  logic [ipWidth-1:0] relTarget;
  logic [ipWidth-1:0] target;
  logic               taken;
  logic               underflow;
  logic               push;
  logic               pop;
  branchResult_t      nextRes;

  logic [ipWidth-1:0]     ras [rasDepth];
  logic [rasPtrWidth-1:0] rasPtr;    // Next free slot.
  logic [rasPtrWidth-1:0] topPtr;
  logic [rasCntWidth-1:0] rasCount;
  logic                   rasEmpty;
  logic                   rasFull;

  assign {n, z, c, v} = flags;
  assign condBits     = jump.cond;

  // ----------------------------------------
  // Condition test
  // ----------------------------------------
  always_comb begin
    case (condBits[3:1])
      3'd0:    condTest = z;
      3'd1:    condTest = c;
      3'd2:    condTest = n;
      3'd3:    condTest = v;
      3'd4:    condTest = c | z;
      3'd5:    condTest = n ^ v;
      3'd6:    condTest = (n ^ v) | z;
      default: condTest = 1'b1;
    endcase
    condHolds = condTest ^ condBits[0];  // Odd codes invert.
  end

  assign fallThru  = ip + ipWidth'(info.len);
  assign relTarget = ip + info.offset;

  assign topPtr   = rasPtr - 1'b1;
  assign rasEmpty = (rasCount == '0);
  assign rasFull  = (rasCount == rasCntWidth'(rasDepth));

  // ----------------------------------------
  // Target selection
  // ----------------------------------------
  always_comb begin
    taken     = 1'b0;
    target    = relTarget;
    underflow = 1'b0;
    push      = 1'b0;
    pop       = 1'b0;
    if (!info.illegal) begin
      case (jump.kind)
        jkCond:   taken = condHolds;
        jkUncond: taken = 1'b1;
        jkCall: begin
          taken = 1'b1;
          push  = 1'b1;
        end
        jkIndir: begin
          taken  = 1'b1;
          target = regTarget;
        end
        jkRet: begin
          if (rasEmpty) begin
            underflow = 1'b1;  // Falls through.
          end else begin
            taken  = 1'b1;
            target = ras[topPtr];
            pop    = 1'b1;
          end
        end
        default: ;
      endcase
    end
    nextRes.nextIp       = info.illegal ? ip : (taken ? target : fallThru);
    nextRes.taken        = taken;
    nextRes.illegal      = info.illegal;
    nextRes.rasUnderflow = underflow;
  end

  // ----------------------------------------
  // Output register and stack control
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
      result   <= '0;
      rasPtr   <= '0;
      rasCount <= '0;
    end else begin
      outValid <= valid;
      if (valid) result <= nextRes;
      if (valid && push) begin
        rasPtr <= rasPtr + 1'b1;  // Wraps over the oldest.
        if (!rasFull) rasCount <= rasCount + 1'b1;
      end else if (valid && pop) begin
        rasPtr   <= topPtr;
        rasCount <= rasCount - 1'b1;
      end
    end
  end

  // Return addresses.
  always_ff @(posedge clk) begin
    if (valid && push) ras[rasPtr] <= fallThru;
  end

endmodule

`default_nettype wire

// File: src/instrClassifier.sv
// ----------------------------------------
// Length-code decode. Gives the byte length,
// the sign-extended jump offset (shifted
// left by one) and the illegal flag.
// An illegal code gives length 0, offset 0.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module instrClassifier (
  input  logic [isaPkg::instrWidth-1:0] instr,
  input  isaPkg::lenCode_e              magic,
  output frontPkg::classInfo_t          info
);

  import isaPkg::*;

  logic [ipWidth-1:0] offShort;
  logic [ipWidth-1:0] offMid;
  logic [ipWidth-1:0] offLong;

  // Offset fields per length, halfword scaled.
  assign offShort = {{(ipWidth-9){instr[15]}}, instr[15:8], 1'b0};
  assign offMid   = {{(ipWidth-17){instr[31]}}, instr[31:16], 1'b0};
  assign offLong  = {{(ipWidth-33){instr[47]}}, instr[47:16], 1'b0};

  always_comb begin
    info.illegal = 1'b0;
    case (magic)
      lenShort: begin
        info.len    = 3'd2;
        info.offset = offShort;
      end
      lenMid: begin
        info.len    = 3'd4;
        info.offset = offMid;
      end
      lenLong: begin
        info.len    = 3'd6;
        info.offset = offLong;
      end
      default: begin  // lenIllegal.
        info.len     = 3'd0;
        info.offset  = '0;
        info.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/jumpDecoder.sv
// ----------------------------------------
// Opcode decode into jump kind and condition.
// Purely combinational. The length code is
// not looked at here; illegal lengths are
// handled in the resolver.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module jumpDecoder (
  input  logic [isaPkg::instrWidth-1:0] instr,
  output frontPkg::jumpInfo_t           jump
);

  import isaPkg::*;

  logic [7:0] opcode;
  logic [2:0] subOp;
  logic       isCondJump;
  logic       isUncondJump;
  logic       isGroup;

  assign opcode = instr[7:0];
  assign subOp  = instr[15:13];  // Only meaningful for the group opcode.

  // ----------------------------------------
  // Opcode match
  // ----------------------------------------
  assign isCondJump   = (opcode[7:4] == opCondBase);
  assign isUncondJump = (opcode == opJmp);
  assign isGroup      = (opcode == opGroup);

  // ----------------------------------------
  // Kind and condition
  // ----------------------------------------
  always_comb begin
    jump.kind = jkNone;
    jump.cond = condAlways;  // Default for everything but A0..AF.
    if (isCondJump) begin
      jump.kind = jkCond;
      jump.cond = cond_e'(opcode[3:0]);
    end else if (isUncondJump) begin
      jump.kind = jkUncond;
    end else if (isGroup) begin
      case (subOp)
        subIndir: jump.kind = jkIndir;
        subCall:  jump.kind = jkCall;
        subRet:   jump.kind = jkRet;
        default:  jump.kind = jkNone;  // Unused group slots.
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/frontPkg.sv
// ----------------------------------------
// Records passed between the front-end
// decode blocks. The return stack depth must
// be a power of two, since the pointer wraps.
// ----------------------------------------
`default_nettype none

package frontPkg;

  localparam int rasDepth = 8;                     // Return stack entries.
  localparam int rasPtrWidth = $clog2(rasDepth);
  localparam int rasCntWidth = rasPtrWidth + 1;    // Counts 0..rasDepth.

  // Output of the opcode decoder.
  typedef struct packed {
    isaPkg::jumpKind_e kind;
    isaPkg::cond_e     cond;
  } jumpInfo_t;

  // Output of the length-code classifier.
  typedef struct packed {
    logic [2:0]                 len;      // Bytes.
    logic [isaPkg::ipWidth-1:0] offset;   // Sign-extended, bit 0 clear.
    logic                       illegal;
  } classInfo_t;

  // Registered resolver result.
  typedef struct packed {
    logic [isaPkg::ipWidth-1:0] nextIp;
    logic                       taken;
    logic                       illegal;
    logic                       rasUnderflow;
  } branchResult_t;

endpackage

`default_nettype wire

// File: src/isaPkg.sv
// ----------------------------------------
// Instruction-set constants for the branch
// decode slice. Only the jump opcodes are
// listed here; all other opcodes decode as
// non-jumps.
// ----------------------------------------
`default_nettype none

package isaPkg;

  localparam int ipWidth = 48;     // Instruction address.
  localparam int instrWidth = 48;  // Longest instruction word.

  // Two-bit length code carried beside the instruction.
  typedef enum logic [1:0] {
    lenShort   = 2'b00,  // 2 bytes.
    lenMid     = 2'b01,  // 4 bytes.
    lenIllegal = 2'b10,
    lenLong    = 2'b11   // 6 bytes.
  } lenCode_e;

  typedef enum logic [2:0] {
    jkNone   = 3'd0,
    jkCond   = 3'd1,
    jkUncond = 3'd2,
    jkCall   = 3'd3,
    jkRet    = 3'd4,
    jkIndir  = 3'd5
  } jumpKind_e;

  // Bits 3..1 pick the flag test, bit 0 inverts it.
  typedef enum logic [3:0] {
    condZ      = 4'd0,
    condNz     = 4'd1,
    condC      = 4'd2,
    condNc     = 4'd3,
    condN      = 4'd4,
    condNn     = 4'd5,
    condV      = 4'd6,
    condNv     = 4'd7,
    condCz     = 4'd8,   // C or Z.
    condNcz    = 4'd9,
    condLt     = 4'd10,  // N xor V.
    condGe     = 4'd11,
    condLe     = 4'd12,  // (N xor V) or Z.
    condGt     = 4'd13,
    condAlways = 4'd14,
    condNever  = 4'd15
  } cond_e;

  // ----------------------------------------
  // Opcodes
  // ----------------------------------------
  localparam logic [3:0] opCondBase = 4'hA;  // A0..AF, low nibble is the condition.

  typedef enum logic [7:0] {
    opJmp   = 8'hB5,
    opGroup = 8'hB6   // Sub-operation in bits 15..13.
  } opcode_e;

  typedef enum logic [2:0] {
    subIndir = 3'd0,
    subCall  = 3'd1,
    subRet   = 3'd3
  } groupOp_e;

endpackage

`default_nettype wire
